/* tb/dnn_patterns.txt */
// per weight set: 32 weights (3 hex digits, 10-bit signed), one line per output neuron
// then 3 samples: 16 input activations, one-hot label, expected one-hot class
// set 0: mixed weights, each sample favours a different neuron
040 040 040 040 040 040 040 040
040 040 040 040 040 040 040 040
080 080 080 080 3C0 3C0 3C0 3C0
3C0 3C0 3C0 3C0 080 080 080 080
80 00 80 00 80 00 80 00 80 00 80 00 80 00 80 00 1 1
00 00 00 00 00 00 00 00 00 FF 00 FF 00 FF 00 FF 2 8
C8 00 C8 00 C8 00 C8 00 00 00 00 00 00 00 00 00 4 4
// set 1: all weights negative, every neuron clamps to 0
3FF 3FF 3FF 3FF 3FF 3FF 3FF 3FF
3FF 3FF 3FF 3FF 3FF 3FF 3FF 3FF
3FF 3FF 3FF 3FF 3FF 3FF 3FF 3FF
3FF 3FF 3FF 3FF 3FF 3FF 3FF 3FF
FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF 1 1
10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 10 8 1
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 1 1
// set 2: large weights, neurons 1 to 3 saturate at 511
001 001 001 001 001 001 001 001
1FF 1FF 1FF 1FF 1FF 1FF 1FF 1FF
1FF 1FF 1FF 1FF 1FF 1FF 1FF 1FF
1FF 1FF 1FF 1FF 1FF 1FF 1FF 1FF
FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF 2 2
FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 FF 00 8 4
00 40 00 40 00 40 00 40 00 40 00 40 00 40 00 40 2 2

/* flist.f */
+incdir+verilog
verilog/dnn_pkg.sv
verilog/block_counter.sv
verilog/act_buffer.sv
verilog/sparse_junction.sv
verilog/output_argmax.sv
verilog/dnn_top.sv
tb/tb_dnn.sv

/* Makefile */
sim:
	verilator --binary --top-module tb_dnn --Mdir obj_dir -f flist.f
	./obj_dir/Vtb_dnn | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* tb/tb_dnn.sv */
// testbench of the sparse network classifier
// file patterns, LFSR streams, reference model and output checks
`default_nettype none

`include "dnn_params.svh"

module tb_dnn;

	localparam int N_W = `DNN_N_OUT * `DNN_FI; // 32 weights
	localparam int SET_WORDS = N_W + 3 * (`DNN_N_IN + 2); // one weight set and its samples

	typedef struct packed {
		logic            chk; // class and hit are compared
		logic [2:0]      test;
		dnn_pkg::class_t cls;
		dnn_pkg::class_t lbl;
	} exp_t;

	logic clk = 1'b0;
	logic cycle_clk;
	dnn_pkg::act_group_t a_in;
	dnn_pkg::class_t y_in;
	dnn_pkg::weight_wr_t w_wr;
	dnn_pkg::class_t a_out_alln;
	dnn_pkg::class_t y_out;
	logic hit;
	logic result_valid;

	logic [11:0] pat [3*SET_WORDS];
	string names [5] = '{"reset", "file_normal", "file_negative", "file_saturate", "random"};
	exp_t exp_q [$];
	int smp [`DNN_N_IN]; // sample being loaded
	int model_w [N_W]; // weights in the DUT
	int new_w [N_W]; // weights to be written
	int wr_ptr = N_W;
	int blk_pos = 0; // block index as seen by the driver
	int errors = 0;
	logic [2:0] test_id = 3'd0;
	logic seen = 1'b0; // first result has arrived
	logic done = 1'b0;
	logic [31:0] lfsr = 32'hf8836280;

	dnn_top UUT (
		.clk         (clk),
		.cycle_clk   (cycle_clk),
		.a_in        (a_in),
		.y_in        (y_in),
		.w_wr        (w_wr),
		.a_out_alln  (a_out_alln),
		.y_out       (y_out),
		.hit         (hit),
		.result_valid(result_valid)
	);

	always #50 clk = ~clk;

	// galois LFSR, one step per bit
	function automatic int rand_bits(input int n);
		int r;
		logic lsb;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb) lfsr = lfsr ^ 32'h80200003;
			r = (r << 1) | int'(lsb);
		end
		return r;
	endfunction

	// interleaved taps, sum >> 8, relu, clip at 511, lowest index on a tie
	function automatic dnn_pkg::class_t model_class();
		int best;
		int bidx;
		int sum;
		int act;
		best = -1;
		bidx = 0;
		for (int j = 0; j < `DNN_N_OUT; j++) begin
			sum = 0;
			for (int m = 0; m < `DNN_FI; m++) sum += smp[2 * m + j % 2] * model_w[8 * j + m];
			act = sum >>> 8;
			if (act < 0) act = 0;
			if (act > 511) act = 511;
			if (act > best) begin
				best = act;
				bidx = j;
			end
		end
		return 4'b0001 << bidx;
	endfunction

	// one 6-clock block: 4 groups, label at index 0, pending weight writes
	task automatic run_block(input dnn_pkg::class_t lbl, input logic chk,
		input dnn_pkg::class_t cls);
		exp_q.push_back('{chk: chk, test: test_id, cls: cls, lbl: lbl});
		for (int c = 0; c < `DNN_CPC; c++) begin
			blk_pos = c;
			a_in = '0;
			for (int k = 0; k < `DNN_GROUP; k++) begin
				if (c < 4) a_in.a[k] = dnn_pkg::act_in_t'(smp[4 * c + k]);
			end
			y_in = (c == 0) ? lbl : '0;
			w_wr = '0;
			if (wr_ptr < N_W) begin
				w_wr.we = 1'b1;
				w_wr.addr = dnn_pkg::w_addr_t'(wr_ptr);
				w_wr.data = dnn_pkg::weight_t'(new_w[wr_ptr]);
				wr_ptr++;
			end
			@(posedge clk);
			#1;
		end
	endtask

	task automatic clear_sample();
		for (int i = 0; i < `DNN_N_IN; i++) smp[i] = 0;
	endtask

	// flush block first so no checked sample sees a weight change
	task automatic load_weights();
		clear_sample();
		run_block('0, 1'b0, '0);
		wr_ptr = 0;
		while (wr_ptr < N_W) run_block('0, 1'b0, '0);
		for (int i = 0; i < N_W; i++) model_w[i] = new_w[i];
	endtask

	task automatic file_set(input int s);
		int base;
		dnn_pkg::class_t lbl;
		dnn_pkg::class_t cls;
		base = s * SET_WORDS;
		for (int i = 0; i < N_W; i++) new_w[i] = int'($signed(pat[base + i][9:0]));
		load_weights();
		test_id = 3'(s + 1);
		for (int n = 0; n < 3; n++) begin
			base = s * SET_WORDS + N_W + n * (`DNN_N_IN + 2);
			for (int i = 0; i < `DNN_N_IN; i++) smp[i] = int'(pat[base + i][7:0]);
			lbl = pat[base + `DNN_N_IN][3:0];
			cls = pat[base + `DNN_N_IN + 1][3:0];
			assert (model_class() == cls) else begin
				errors++;
				$display("ERR %s model: expected %b actual %b", names[test_id], cls, model_class());
			end
			run_block(lbl, 1'b1, cls); // samples back to back
		end
	endtask

	// outputs are compared away from the rising edge
	always @(negedge clk) begin
		exp_t e;
		if (cycle_clk || (!seen && !result_valid)) begin
			assert (!result_valid && !hit && a_out_alln == '0 && y_out == '0) else begin
				errors++;
				$display("ERR reset: expected 0 actual %b %b %b %b", result_valid, hit,
					a_out_alln, y_out);
			end
		end else if (result_valid && !done) begin
			seen = 1'b1;
			assert (blk_pos == 0) else begin
				errors++;
				$display("result_valid came at block index %0d instead of 0", blk_pos);
			end
			if (exp_q.size() == 0) begin
				errors++;
				$display("result_valid came with no sample outstanding");
			end else begin
				e = exp_q.pop_front();
				assert (y_out == e.lbl) else begin
					errors++;
					$display("ERR %s label: expected %b actual %b", names[e.test], e.lbl, y_out);
				end
				if (e.chk) begin
					assert (a_out_alln == e.cls) else begin
						errors++;
						$display("ERR %s class: expected %b actual %b", names[e.test], e.cls,
							a_out_alln);
					end
					assert (hit == (e.cls == e.lbl)) else begin
						errors++;
						$display("ERR %s hit: expected %b actual %b", names[e.test],
							e.cls == e.lbl, hit);
					end
				end
			end
		end
	end

	initial begin
		int t;
		cycle_clk = 1'b1;
		a_in = '0;
		y_in = '0;
		w_wr = '0;
		$readmemh("tb/dnn_patterns.txt", pat);
		exp_q.push_back('{chk: 1'b1, test: 3'd0, cls: 4'b0001, lbl: 4'b0000}); // reset bank
		repeat (10) @(posedge clk);
		#1;
		cycle_clk = 1'b0; // first clock after release is index 0
		for (int s = 0; s < 3; s++) file_set(s);
		for (int r = 0; r < 3; r++) begin
			for (int i = 0; i < N_W; i++) new_w[i] = int'($signed(8'(rand_bits(8))));
			load_weights();
			test_id = 3'd4;
			for (int n = 0; n < 8; n++) begin
				for (int i = 0; i < `DNN_N_IN; i++) smp[i] = rand_bits(8);
				run_block(4'b0001 << rand_bits(2), 1'b1, model_class());
			end
		end
		// drain: the block position keeps counting with the DUT
		t = 0;
		blk_pos = 0;
		while (exp_q.size() > 0 && t < 20 * `DNN_CPC) begin
			@(posedge clk);
			#1;
			blk_pos = (blk_pos + 1) % `DNN_CPC;
			t++;
		end
		done = 1'b1;
		if (exp_q.size() > 0) begin
			errors++;
			$display("timeout: %0d results never arrived on result_valid", exp_q.size());
		end
		$display("checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/dnn_top.sv */
// top level of the sparse network classifier
// counter, input buffer, junction and argmax wired together
`default_nettype none

`include "dnn_params.svh"

module dnn_top (
	input  logic                clk,
	input  logic                cycle_clk, // async reset, active high
	input  dnn_pkg::act_group_t a_in, // 4 inputs per clock at index 0 .. 3
	input  dnn_pkg::class_t     y_in, // label, sampled at index 0
	input  dnn_pkg::weight_wr_t w_wr,
	output dnn_pkg::class_t     a_out_alln,
	output dnn_pkg::class_t     y_out,
	output logic                hit,
	output logic                result_valid
);

	dnn_pkg::cycle_idx_t              index;
	logic                             block_start;
	dnn_pkg::act_in_t [`DNN_N_IN-1:0] acts; // sample being computed
	dnn_pkg::neuron_res_t             res;

	block_counter u_block_counter (
		.clk        (clk),
		.cycle_clk  (cycle_clk),
		.index      (index),
		.block_start(block_start)
	);

	act_buffer u_act_buffer (
		.clk        (clk),
		.cycle_clk  (cycle_clk),
		.index      (index),
		.block_start(block_start),
		.a_in       (a_in),
		.acts       (acts)
	);

	sparse_junction u_sparse_junction (
		.clk      (clk),
		.cycle_clk(cycle_clk),
		.index    (index),
		.acts     (acts),
		.w_wr     (w_wr),
		.res      (res)
	);

	output_argmax u_output_argmax (
		.clk         (clk),
		.cycle_clk   (cycle_clk),
		.block_start (block_start),
		.res         (res),
		.y_in        (y_in),
		.a_out_alln  (a_out_alln),
		.y_out       (y_out),
		.hit         (hit),
		.result_valid(result_valid)
	);

endmodule

`default_nettype wire

/* verilog/output_argmax.sv */
// output classification: running max over the output neurons of a block,
// one-hot class, two-deep label delay line and hit flag
`default_nettype none

`include "dnn_params.svh"

module output_argmax (
	input  logic                 clk,
	input  logic                 cycle_clk,
	input  logic                 block_start,
	input  dnn_pkg::neuron_res_t res,
	input  dnn_pkg::class_t      y_in,
	output dnn_pkg::class_t      a_out_alln, // predicted class, one-hot
	output dnn_pkg::class_t      y_out, // label of the same sample
	output logic                 hit,
	output logic                 result_valid
);

	// most negative value when read as signed, so the first neuron always wins
	localparam dnn_pkg::act_t ACT_MOST_NEG = {1'b1, {(`DNN_WIDTH - 1){1'b0}}};
	localparam dnn_pkg::neuron_idx_t LAST_NEURON = dnn_pkg::neuron_idx_t'(`DNN_N_OUT - 1);

	dnn_pkg::act_t        max_q;
	dnn_pkg::neuron_idx_t max_idx_q;
	dnn_pkg::act_t        max_nx;
	dnn_pkg::neuron_idx_t idx_nx;
	dnn_pkg::class_t      class_nx;
	dnn_pkg::class_t      lbl_q [2]; // [0] sample loading, [1] sample computing
	logic                 last; // last neuron of the block arrives

	// strictly greater, so a tie keeps the lower index
	always_comb begin
		max_nx = max_q;
		idx_nx = max_idx_q;
		if (res.valid && ($signed(res.act) > $signed(max_q))) begin
			max_nx = res.act;
			idx_nx = res.idx;
		end
	end

	assign class_nx = dnn_pkg::class_t'(1) << idx_nx;
	assign last = res.valid && (res.idx == LAST_NEURON);

	// running maximum, cleared once per block
	always_ff @(posedge clk or posedge cycle_clk) begin
		if (cycle_clk) begin
			max_q <= ACT_MOST_NEG;
			max_idx_q <= '0;
		end else if (block_start) begin
			max_q <= ACT_MOST_NEG; // no results arrive at index 0
			max_idx_q <= '0;
		end else begin
			max_q <= max_nx;
			max_idx_q <= idx_nx;
		end
	end

	// label travels with its sample: loaded in block k, reported in block k+2
	always_ff @(posedge clk or posedge cycle_clk) begin
		if (cycle_clk) begin
			lbl_q[0] <= '0;
			lbl_q[1] <= '0;
		end else if (block_start) begin
			lbl_q[0] <= y_in;
			lbl_q[1] <= lbl_q[0];
		end
	end

	// publish together with the last neuron so the class is out at block_start
	always_ff @(posedge clk or posedge cycle_clk) begin
		if (cycle_clk) begin
			a_out_alln <= '0;
			y_out <= '0;
			hit <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= last; // one clock, lands on index 0
			if (last) begin
				a_out_alln <= class_nx;
				y_out <= lbl_q[1];
				hit <= (class_nx == lbl_q[1]);
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/sparse_junction.sv */
// sparse junction: weight memory, interleaved input select,
// product stage and sum / scale / relu / saturate stage
`default_nettype none

`include "dnn_params.svh"

module sparse_junction (
	input  logic                             clk,
	input  logic                             cycle_clk,
	input  dnn_pkg::cycle_idx_t              index,
	input  dnn_pkg::act_in_t [`DNN_N_IN-1:0] acts,
	input  dnn_pkg::weight_wr_t              w_wr,
	output dnn_pkg::neuron_res_t             res
);

	localparam int PROD_W = `DNN_WIDTH_IN + 1 + `DNN_WIDTH; // unsigned act * signed weight
	localparam int SUM_W = PROD_W + $clog2(`DNN_Z); // room for the 8-way sum
	// product has WIDTH_IN + FRAC fraction bits, the result keeps FRAC
	localparam int SHIFT = `DNN_WIDTH_IN + `DNN_FRAC - `DNN_FRAC;
	localparam logic signed [SUM_W-1:0] ACT_MAX = SUM_W'(2 ** (`DNN_WIDTH - 1) - 1); // 511

	dnn_pkg::weight_t w_mem [`DNN_N_OUT*`DNN_FI]; // address = neuron * 8 + tap

	dnn_pkg::neuron_idx_t neuron; // neuron handled this clock
	dnn_pkg::weight_t     w_sel [`DNN_Z];
	dnn_pkg::act_in_t     a_sel [`DNN_Z];

	// stage 1 registers
	logic signed [PROD_W-1:0] prod_q [`DNN_Z];
	logic                     prod_valid_q;
	dnn_pkg::neuron_idx_t     prod_idx_q;

	// stage 2
	logic signed [SUM_W-1:0] sum;
	logic signed [SUM_W-1:0] sum_sh;
	dnn_pkg::act_t           act_sat;
	logic                    res_valid_q;
	dnn_pkg::neuron_idx_t    res_idx_q;
	dnn_pkg::act_t           res_act_q;

	// weight loading
	always_ff @(posedge clk or posedge cycle_clk) begin
		if (cycle_clk) begin
			for (int i = 0; i < `DNN_N_OUT * `DNN_FI; i++) begin
				w_mem[i] <= '0;
			end
		end else if (w_wr.we) begin
			w_mem[w_wr.addr] <= w_wr.data;
		end
	end

	assign neuron = dnn_pkg::neuron_idx_t'(index); // only meaningful for index 0 .. 3

	// neuron j uses inputs j mod 2, j mod 2 + 2, ... (interleaved by fan-out)
	always_comb begin
		for (int m = 0; m < `DNN_Z; m++) begin
			w_sel[m] = w_mem[dnn_pkg::w_addr_t'(int'(neuron) * `DNN_FI + m)];
			a_sel[m] = acts[`DNN_FO * m + int'(neuron) % `DNN_FO]; // tap m
		end
	end

	// stage 1: 8 multipliers
	always_ff @(posedge clk or posedge cycle_clk) begin
		if (cycle_clk) begin
			prod_valid_q <= 1'b0;
			prod_idx_q <= '0;
			for (int m = 0; m < `DNN_Z; m++) begin
				prod_q[m] <= '0;
			end
		end else begin
			prod_valid_q <= (index < dnn_pkg::cycle_idx_t'(`DNN_N_OUT)); // idle at 4, 5
			prod_idx_q <= neuron;
			for (int m = 0; m < `DNN_Z; m++) begin
				prod_q[m] <= $signed({1'b0, a_sel[m]}) * w_sel[m]; // act is unsigned
			end
		end
	end

	// stage 2: adder tree, rescale, relu and clip
	always_comb begin
		sum = '0;
		for (int m = 0; m < `DNN_Z; m++) begin
			sum = sum + SUM_W'(prod_q[m]); // sign extended
		end
	end

	assign sum_sh = sum >>> SHIFT;

	always_comb begin
		if (sum_sh < 0) begin
			act_sat = '0; // relu
		end else if (sum_sh > ACT_MAX) begin
			act_sat = dnn_pkg::act_t'(ACT_MAX); // clip at 511
		end else begin
			act_sat = dnn_pkg::act_t'(sum_sh);
		end
	end

	always_ff @(posedge clk or posedge cycle_clk) begin
		if (cycle_clk) begin
			res_valid_q <= 1'b0;
			res_idx_q <= '0;
			res_act_q <= '0;
		end else begin
			res_valid_q <= prod_valid_q; // neurons 0 .. 3 land at index 2 .. 5
			res_idx_q <= prod_idx_q;
			res_act_q <= act_sat;
		end
	end

	assign res = '{valid: res_valid_q, idx: res_idx_q, act: res_act_q};

endmodule

`default_nettype wire

/* verilog/act_buffer.sv */
// double-buffered input activation store
// one bank fills with the next sample while the other feeds the junction
`default_nettype none

`include "dnn_params.svh"

module act_buffer (
	input  logic                                      clk,
	input  logic                                      cycle_clk,
	input  dnn_pkg::cycle_idx_t                       index,
	input  logic                                      block_start,
	input  dnn_pkg::act_group_t                       a_in,
	output dnn_pkg::act_in_t [`DNN_N_IN-1:0]          acts
);

	localparam int N_GROUPS = `DNN_N_IN / `DNN_GROUP; // loading clocks per block

	dnn_pkg::act_in_t [`DNN_N_IN-1:0] bank_q [2];
	logic rd_sel_q; // read bank held over the block
	logic rd_sel; // read bank seen this clock
	logic fill_sel;

	// the swap is visible already during block_start, so index 0 of a new block
	// reads the sample that was completed in the block before
	assign rd_sel = rd_sel_q ^ block_start;
	assign fill_sel = ~rd_sel; // fill bank is always the other one

	always_ff @(posedge clk or posedge cycle_clk) begin
		if (cycle_clk) begin
			rd_sel_q <= 1'b0;
		end else begin
			rd_sel_q <= rd_sel; // toggles once per block
		end
	end

	// banks come out of reset as an all-zero sample
	always_ff @(posedge clk or posedge cycle_clk) begin
		if (cycle_clk) begin
			bank_q[0] <= '0;
			bank_q[1] <= '0;
		end else if (index < dnn_pkg::cycle_idx_t'(N_GROUPS)) begin
			// group c carries inputs 4c .. 4c+3
			for (int k = 0; k < `DNN_GROUP; k++) begin
				bank_q[fill_sel][int'(index) * `DNN_GROUP + k] <= a_in.a[k];
			end
		end
		// index 4 and 5: a_in is ignored
	end

	assign acts = bank_q[rd_sel];

endmodule

`default_nettype wire

/* verilog/block_counter.sv */
// block cycle counter
// index walks 0 .. CPC-1 and wraps, block_start marks index 0
`default_nettype none

`include "dnn_params.svh"

module block_counter (
	input  logic                clk,
	input  logic                cycle_clk, // async reset, active high
	output dnn_pkg::cycle_idx_t index,
	output logic                block_start
);

	localparam dnn_pkg::cycle_idx_t LAST_IDX = dnn_pkg::cycle_idx_t'(`DNN_CPC - 1);

	always_ff @(posedge clk or posedge cycle_clk) begin
		if (cycle_clk) begin
			index <= '0;
		end else if (index == LAST_IDX) begin
			index <= '0; // wrap into the next block
		end else begin
			index <= index + 1'b1;
		end
	end

	// decoded from the count so every block agrees on where a block begins
	assign block_start = (index == '0);

endmodule

`default_nettype wire

/* verilog/dnn_pkg.sv */
// shared types of the network
// scalar widths with a meaning, plus the bundles passed between blocks
`default_nettype none

`include "dnn_params.svh"

package dnn_pkg;

	// scalars
	typedef logic [`DNN_WIDTH_IN-1:0] act_in_t; // unsigned, value / 256
	typedef logic [`DNN_WIDTH-1:0] act_t; // unsigned, value / 128
	typedef logic signed [`DNN_WIDTH-1:0] weight_t; // signed, value / 128

	typedef logic [$clog2(`DNN_CPC)-1:0] cycle_idx_t; // position in block, 0 .. 5
	typedef logic [$clog2(`DNN_N_OUT)-1:0] neuron_idx_t; // output neuron number
	typedef logic [$clog2(`DNN_N_OUT*`DNN_FI)-1:0] w_addr_t; // neuron * 8 + tap
	typedef logic [`DNN_N_OUT-1:0] class_t; // one-hot class or label

	// one clock worth of input loading, a[0] is the lowest input of the group
	typedef struct packed {
		act_in_t [`DNN_GROUP-1:0] a;
	} act_group_t;

	// weight write strobe
	typedef struct packed {
		logic    we; // write enable, takes effect next clock
		w_addr_t addr;
		weight_t data;
	} weight_wr_t;

	// one finished output neuron
	typedef struct packed {
		logic        valid;
		neuron_idx_t idx;
		act_t        act;
	} neuron_res_t;

endpackage

`default_nettype wire

/* verilog/dnn_params.svh */
// sizes, widths and block timing of the sparse one-junction network
// all blocks derive their array bounds from these

`ifndef DNN_PARAMS_SVH
`define DNN_PARAMS_SVH

// network shape
`define DNN_N_IN 16 // input neurons
`define DNN_N_OUT 4 // output neurons
`define DNN_FI 8 // fan-in of each output neuron
`define DNN_FO 2 // fan-out of each input neuron

// parallelism
`define DNN_Z 8 // weights processed per clock
`define DNN_GROUP 4 // activations loaded per clock

// clocks per block cycle: 32 weights / 8 per clock, plus 2 pipeline clocks
`define DNN_CPC 6

// number formats
`define DNN_WIDTH 10 // activations and weights
`define DNN_WIDTH_IN 8 // input activations, all fraction
`define DNN_FRAC 7 // fractional bits of activations and weights

`endif
